//--- verilog/fetch_pkg.sv
/*
 * fetch unit shared definitions
 * widths, reset constants, opcode and micro-op enums, interface structs
 */
package fetch_pkg;

  // ==============================
  // basic widths and constants
  // ==============================
  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;

  localparam xlen_t RESET_PC = 64'h0000_0000_0000_1000;
  localparam xlen_t PC_STEP  = 64'd4;

  // buffer depth must stay a power of two for pointer wrap
  localparam int FETCH_BUF_DEPTH = 4;
  localparam int BUF_PTR_W       = $clog2(FETCH_BUF_DEPTH);
  localparam int BUF_CNT_W       = $clog2(FETCH_BUF_DEPTH + 1);

  typedef logic [BUF_CNT_W-1:0] buf_count_t;
  typedef logic [BUF_PTR_W-1:0] buf_ptr_t;

  // ==============================
  // opcodes and encodings
  // ==============================
  // major opcode, inst[6:2]
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_OP_IMM = 5'b00100,
    OPC_STORE  = 5'b01000,
    OPC_AMO    = 5'b01011,
    OPC_OP     = 5'b01100
  } opcode_e;

  // addi x0, x0, 0
  localparam inst_t INST_NOP = {12'h000, 5'd0, 3'b000, 5'd0, OPC_OP_IMM, 2'b11};

  // ==============================
  // atomic expansion
  // ==============================
  // state names the item currently held in the decode register
  typedef enum logic [3:0] {
    AMO_IDLE    = 4'd0,
    AMO_MEM_BAR = 4'd1,
    AMO_LRSC    = 4'd2,
    AMO_MV      = 4'd3,
    AMO_LOAD    = 4'd4,
    AMO_GAP     = 4'd5,
    AMO_OP      = 4'd6,
    AMO_STORE   = 4'd7,
    AMO_DONE    = 4'd8
  } amo_state_e;

  typedef enum logic [3:0] {
    UOP_NORMAL    = 4'd0,
    UOP_BARRIER   = 4'd1,
    UOP_AMO_MV    = 4'd2,
    UOP_AMO_LOAD  = 4'd3,
    UOP_AMO_GAP   = 4'd4,
    UOP_AMO_OP    = 4'd5,
    UOP_AMO_STORE = 4'd6,
    UOP_AMO_LRSC  = 4'd7,
    UOP_AMO_DONE  = 4'd8
  } uop_kind_e;

  // ==============================
  // interface structs
  // ==============================
  typedef struct packed {
    logic  en;
    xlen_t pc;
  } icache_req_t;

  typedef struct packed {
    logic  valid;
    inst_t inst;
  } icache_rsp_t;

  typedef struct packed {
    xlen_t pc;
    inst_t inst;
  } fetch_item_t;

  typedef struct packed {
    xlen_t     pc;
    inst_t     inst;
    uop_kind_e kind;
    logic      illegal;
  } decode_item_t;

  typedef struct packed {
    logic  valid;
    xlen_t pc;
  } redirect_t;

endpackage

//--- verilog/pc_sequencer.sv
/*
 * pc sequencer
 * issues one icache request at a time and pairs each response with its pc
 */
module pc_sequencer import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  redirect_t   redirect,
  input  buf_count_t  free_count,
  output icache_req_t icache_req,
  input  icache_rsp_t icache_rsp,
  output logic        push,
  output fetch_item_t push_item
);

  xlen_t fetch_pc;
  xlen_t req_pc;
  logic  req_en;
  logic  outstanding;
  logic  stale;

  logic  room;
  logic  slot_free;
  logic  can_issue;

  // ==============================
  // issue decision
  // ==============================
  // a slot must exist for every response still on its way
  assign room = free_count > buf_count_t'(outstanding);

  // the one outstanding request may retire this very cycle
  assign slot_free = ~outstanding | icache_rsp.valid;

  // never issue from the old stream in a redirect cycle
  assign can_issue = room & slot_free & ~redirect.valid;

  // ==============================
  // pc and request tracking
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc    <= RESET_PC;
      req_en      <= 1'b0;
      outstanding <= 1'b0;
      stale       <= 1'b0;
    end else begin
      req_en <= can_issue;

      if (redirect.valid) begin
        fetch_pc <= redirect.pc;
      end else if (can_issue) begin
        fetch_pc <= fetch_pc + PC_STEP;
      end

      if (can_issue) begin
        outstanding <= 1'b1;
      end else if (icache_rsp.valid) begin
        outstanding <= 1'b0;
      end

      // a response still in flight belongs to the old stream
      if (redirect.valid) begin
        stale <= outstanding & ~icache_rsp.valid;
      end else if (icache_rsp.valid) begin
        stale <= 1'b0;
      end
    end
  end

  // held for the whole life of the request
  always_ff @(posedge clk) begin
    if (can_issue) begin
      req_pc <= fetch_pc;
    end
  end

  assign icache_req.en = req_en;
  assign icache_req.pc = req_pc;

  // ==============================
  // response capture
  // ==============================
  // drop stale words and anything arriving with a redirect
  assign push = icache_rsp.valid & ~stale & ~redirect.valid;

  assign push_item.pc   = req_pc;
  assign push_item.inst = icache_rsp.inst;

endmodule

//--- verilog/fetch_buffer.sv
/*
 * fetch buffer
 * small circular FIFO of fetched words, flushed by a redirect
 */
module fetch_buffer import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  redirect_t   redirect,
  input  logic        push,
  input  fetch_item_t push_item,
  output buf_count_t  free_count,
  output logic        head_valid,
  output fetch_item_t head_item,
  input  logic        pop
);

  fetch_item_t mem [FETCH_BUF_DEPTH];

  buf_ptr_t   wr_ptr;
  buf_ptr_t   rd_ptr;
  buf_count_t count;

  // ==============================
  // storage
  // ==============================
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_item;
    end
  end

  // ==============================
  // pointers and occupancy
  // ==============================
  always_ff @(posedge clk) begin
    if (rst || redirect.valid) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head shows one cycle after the push
  assign head_valid = count != '0;
  assign head_item  = mem[rd_ptr];

  assign free_count = buf_count_t'(FETCH_BUF_DEPTH) - count;

endmodule

//--- verilog/amo_expander.sv
/*
 * atomic expander
 * splits AMO instructions into micro-ops and registers items for decode
 */
module amo_expander import fetch_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  redirect_t    redirect,
  input  logic         head_valid,
  input  fetch_item_t  head_item,
  output logic         pop,
  output logic         decode_valid,
  output decode_item_t decode_item,
  input  logic         decode_ready
);

  amo_state_e state;
  amo_state_e state_nxt;

  inst_t      inst;
  logic [4:0] funct5;
  logic       aq;
  logic       rl;
  logic       is_amo_opc;
  logic       is_amo_mem_op;
  logic       is_lrsc;
  logic       need_bar;

  inst_t mv_inst;
  inst_t load_inst;
  inst_t op_inst;
  inst_t store_inst;

  logic         advance;
  logic         load_en;
  logic         pop_nxt;
  uop_kind_e    nxt_kind;
  inst_t        nxt_inst;
  decode_item_t nxt_item;

  // ==============================
  // classify the head word
  // ==============================
  assign inst   = head_item.inst;
  assign funct5 = inst[31:27];
  assign aq     = inst[26];
  assign rl     = inst[25];

  // only a full 32-bit encoding counts as atomic
  assign is_amo_opc = (inst[6:2] == OPC_AMO) && (inst[1:0] == 2'b11);

  always_comb begin
    case (funct5)
      5'h00, 5'h01, 5'h04, 5'h08, 5'h0c,
      5'h10, 5'h14, 5'h18, 5'h1c: is_amo_mem_op = is_amo_opc;
      default:                    is_amo_mem_op = 1'b0;
    endcase
  end

  assign is_lrsc  = is_amo_opc && ((funct5 == 5'h02) || (funct5 == 5'h03));
  assign need_bar = (is_amo_mem_op || is_lrsc) && (aq || rl);

  // ==============================
  // micro-op rewrites
  // ==============================
  // copy rs2 aside
  assign mv_inst = {7'b0, inst[24:20], 5'd0, 3'b001, 5'd0, OPC_OP, 2'b11};

  // rd <- mem[rs1]
  assign load_inst = {12'h000, inst[19:15], inst[14:12], inst[11:7], OPC_LOAD, 2'b11};

  // old rd value becomes the first operand
  assign op_inst = {inst[31:20], inst[11:7], inst[14:12], 5'd0, inst[6:0]};

  assign store_inst = {7'b0, 5'd0, inst[19:15], inst[14:12], 5'd0, OPC_STORE, 2'b11};

  // ==============================
  // next item and next state
  // ==============================
  always_comb begin
    state_nxt = state;
    load_en   = 1'b1;
    pop_nxt   = 1'b0;
    nxt_kind  = UOP_NORMAL;
    nxt_inst  = INST_NOP;
    case (state)
      // DONE already popped its entry, so the head is the next word
      AMO_IDLE, AMO_DONE: begin
        state_nxt = AMO_IDLE;
        load_en   = head_valid;
        if (head_valid && need_bar) begin
          state_nxt = AMO_MEM_BAR;
          nxt_kind  = UOP_BARRIER;
        end else if (head_valid && is_amo_mem_op) begin
          state_nxt = AMO_MV;
          nxt_kind  = UOP_AMO_MV;
          nxt_inst  = mv_inst;
        end else begin
          nxt_inst = inst;
          pop_nxt  = head_valid;
        end
      end
      AMO_MEM_BAR: begin
        if (is_lrsc) begin
          state_nxt = AMO_LRSC;
          nxt_kind  = UOP_AMO_LRSC;
          nxt_inst  = inst;
        end else begin
          state_nxt = AMO_MV;
          nxt_kind  = UOP_AMO_MV;
          nxt_inst  = mv_inst;
        end
      end
      AMO_MV: begin
        state_nxt = AMO_LOAD;
        nxt_kind  = UOP_AMO_LOAD;
        nxt_inst  = load_inst;
      end
      AMO_LOAD: begin
        state_nxt = AMO_GAP;
        nxt_kind  = UOP_AMO_GAP;
      end
      AMO_GAP: begin
        state_nxt = AMO_OP;
        nxt_kind  = UOP_AMO_OP;
        nxt_inst  = op_inst;
      end
      AMO_OP: begin
        state_nxt = AMO_STORE;
        nxt_kind  = UOP_AMO_STORE;
        nxt_inst  = store_inst;
      end
      // last item of the sequence releases the buffer entry
      AMO_STORE, AMO_LRSC: begin
        state_nxt = AMO_DONE;
        nxt_kind  = UOP_AMO_DONE;
        pop_nxt   = 1'b1;
      end
      default: begin
        state_nxt = AMO_IDLE;
        load_en   = 1'b0;
      end
    endcase
  end

  assign nxt_item.pc      = head_item.pc;
  assign nxt_item.inst    = nxt_inst;
  assign nxt_item.kind    = nxt_kind;
  assign nxt_item.illegal = inst[1:0] != 2'b11;

  // output slot is free or being taken this cycle
  assign advance = ~decode_valid | decode_ready;

  assign pop = advance & pop_nxt & ~redirect.valid;

  // ==============================
  // decode output register
  // ==============================
  always_ff @(posedge clk) begin
    if (rst || redirect.valid) begin
      state        <= AMO_IDLE;
      decode_valid <= 1'b0;
    end else if (advance) begin
      state        <= state_nxt;
      decode_valid <= load_en;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && load_en) begin
      decode_item <= nxt_item;
    end
  end

endmodule

//--- verilog/fetch_unit.sv
/*
 * instruction fetch front end
 * pc sequencer, fetch buffer and atomic expander in one pipeline
 */
module fetch_unit import fetch_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  output icache_req_t  icache_req,
  input  icache_rsp_t  icache_rsp,
  input  redirect_t    redirect,
  output logic         decode_valid,
  output decode_item_t decode_item,
  input  logic         decode_ready
);

  // sequencer to buffer
  logic        push;
  fetch_item_t push_item;
  buf_count_t  free_count;

  // buffer to expander
  logic        head_valid;
  fetch_item_t head_item;
  logic        pop;

  // ==============================
  // request side
  // ==============================
  pc_sequencer pc_sequencer_i (
    .clk        (clk),
    .rst        (rst),
    .redirect   (redirect),
    .free_count (free_count),
    .icache_req (icache_req),
    .icache_rsp (icache_rsp),
    .push       (push),
    .push_item  (push_item)
  );

  fetch_buffer fetch_buffer_i (
    .clk        (clk),
    .rst        (rst),
    .redirect   (redirect),
    .push       (push),
    .push_item  (push_item),
    .free_count (free_count),
    .head_valid (head_valid),
    .head_item  (head_item),
    .pop        (pop)
  );

  // ==============================
  // decode side
  // ==============================
  amo_expander amo_expander_i (
    .clk          (clk),
    .rst          (rst),
    .redirect     (redirect),
    .head_valid   (head_valid),
    .head_item    (head_item),
    .pop          (pop),
    .decode_valid (decode_valid),
    .decode_item  (decode_item),
    .decode_ready (decode_ready)
  );

endmodule

//--- testbench/icache_model.sv
/*
 * instruction memory model
 * answers each fetch request after a random delay of 1 to 3 cycles
 */
module icache_model import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  icache_req_t req,
  output icache_rsp_t rsp
);
  timeunit 1ns;
  timeprecision 100ps;

  // 64 words, indexed by pc[7:2]
  inst_t  words [64];

  integer seed;
  logic   pending;
  int     delay;
  xlen_t  pend_pc;

  initial begin
    seed    = 2978;
    rsp     = '0;
    pending = 1'b0;
    delay   = 0;
    pend_pc = '0;
  end

  // response moves on the falling edge, away from the sampling edge
  always @(negedge clk) begin
    rsp.valid = 1'b0;
    if (rst) begin
      pending = 1'b0;
    end else begin
      if (pending) begin
        delay = delay - 1;
        if (delay == 0) begin
          rsp.valid = 1'b1;
          rsp.inst  = words[pend_pc[7:2]];
          pending   = 1'b0;
        end
      end
      // new request seen in the cycle it is raised
      if (req.en) begin
        pending = 1'b1;
        pend_pc = req.pc;
        delay   = 1 + ($unsigned($random(seed)) % 3);
      end
    end
  end

endmodule

//--- testbench/tb_fetch_unit.sv
/*
 * fetch unit testbench
 * random program, random stalls and redirects, checked against a reference model
 */
module tb_fetch_unit import fetch_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    CLK_PERIOD     = 100;
  localparam int    NUM_TESTS      = 3;
  localparam int    TEST_ITEMS     = 300;
  localparam int    TIMEOUT_CYCLES = NUM_TESTS * TEST_ITEMS * 20 + 1000;
  localparam inst_t NOP_WORD       = 32'h0000_0013;

  logic         clk;
  logic         rst;
  icache_req_t  icache_req;
  icache_rsp_t  icache_rsp;
  redirect_t    redirect;
  logic         decode_valid;
  decode_item_t decode_item;
  logic         decode_ready;

  integer seed;
  int     errors;
  int     total_items;

  // reference model of the current instruction
  xlen_t        exp_pc;
  uop_kind_e    exp_kind [8];
  inst_t        exp_inst [8];
  logic         exp_illegal;
  int           exp_cnt;
  int           exp_idx;
  logic         hold_pending;
  decode_item_t hold_item;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fetch_unit fetch_unit_i (
    .clk          (clk),
    .rst          (rst),
    .icache_req   (icache_req),
    .icache_rsp   (icache_rsp),
    .redirect     (redirect),
    .decode_valid (decode_valid),
    .decode_item  (decode_item),
    .decode_ready (decode_ready)
  );

  icache_model icache_model_i (
    .clk (clk),
    .rst (rst),
    .req (icache_req),
    .rsp (icache_rsp)
  );

  // ==============================
  // program and reference model
  // ==============================
  task automatic fill_table();
    inst_t w;
    int    sel;
    for (int i = 0; i < 64; i++) begin
      w   = $random(seed);
      sel = $unsigned($random(seed)) % 6;
      case (sel)
        0, 1: w[1:0] = 2'b11;
        // memory-op atomics with random aq/rl
        2, 3: begin
          w[6:0]   = 7'b0101111;
          w[31:27] = (sel == 2) ? 5'd1 : {w[31:29], 2'b00};
        end
        // LR or SC
        4: begin
          w[6:0]   = 7'b0101111;
          w[31:27] = {4'b0001, w[27]};
        end
        default: w[1:0] = $unsigned($random(seed)) % 3;
      endcase
      icache_model_i.words[i] = w;
    end
  endtask

  task automatic add_uop(input uop_kind_e kind, input inst_t inst);
    exp_kind[exp_cnt] = kind;
    exp_inst[exp_cnt] = inst;
    exp_cnt++;
  endtask

  task automatic build_expected(input xlen_t pc);
    inst_t      w;
    logic [4:0] f5;
    logic       mem_op;
    logic       lr_sc;
    logic       ordered;
    w           = icache_model_i.words[pc[7:2]];
    f5          = w[31:27];
    mem_op      = (w[6:0] == 7'b0101111) && (f5 == 5'd1 || f5[1:0] == 2'b00);
    lr_sc       = (w[6:0] == 7'b0101111) && (f5 == 5'd2 || f5 == 5'd3);
    ordered     = w[26] | w[25];
    exp_pc      = pc;
    exp_cnt     = 0;
    exp_idx     = 0;
    exp_illegal = w[1:0] != 2'b11;
    if ((mem_op || lr_sc) && ordered) begin
      add_uop(UOP_BARRIER, NOP_WORD);
    end
    if (mem_op) begin
      add_uop(UOP_AMO_MV, {7'd0, w[24:20], 5'd0, 3'd1, 5'd0, 7'b0110011});
      add_uop(UOP_AMO_LOAD, {12'd0, w[19:15], w[14:12], w[11:7], 7'b0000011});
      add_uop(UOP_AMO_GAP, NOP_WORD);
      add_uop(UOP_AMO_OP, {w[31:20], w[11:7], w[14:12], 5'd0, w[6:0]});
      add_uop(UOP_AMO_STORE, {12'd0, w[19:15], w[14:12], 5'd0, 7'b0100011});
      add_uop(UOP_AMO_DONE, NOP_WORD);
    end else if (lr_sc && ordered) begin
      add_uop(UOP_AMO_LRSC, w);
      add_uop(UOP_AMO_DONE, NOP_WORD);
    end else begin
      add_uop(UOP_NORMAL, w);
    end
  endtask

  // ==============================
  // per-cycle checks
  // ==============================
  // called on the falling edge once this cycle's inputs are driven
  task automatic check_cycle();
    if (hold_pending) begin
      assert (decode_valid && decode_item == hold_item) else begin
        $display("** Error at %0t: decode item changed while stalled", $time);
        errors++;
      end
    end
    if (decode_valid && decode_ready) begin
      assert (decode_item.pc == exp_pc && decode_item.kind == exp_kind[exp_idx]
              && decode_item.inst == exp_inst[exp_idx]
              && decode_item.illegal == exp_illegal) else begin
        $display("** Error at %0t: got pc %h kind %0d inst %h illegal %b", $time,
                 decode_item.pc, decode_item.kind, decode_item.inst, decode_item.illegal);
        $display("** Error at %0t: expected pc %h kind %0d inst %h illegal %b", $time,
                 exp_pc, exp_kind[exp_idx], exp_inst[exp_idx], exp_illegal);
        errors++;
      end
      total_items++;
      exp_idx++;
      if (exp_idx == exp_cnt) begin
        build_expected(exp_pc + 64'd4);
      end
    end
    hold_pending = decode_valid && !decode_ready && !redirect.valid;
    hold_item    = decode_item;
    // the item taken in the redirect cycle still belongs to the old stream
    if (redirect.valid) begin
      build_expected(redirect.pc);
    end
  endtask

  task automatic run_test(input string name, input int ready_pct, input int redirect_pct);
    int start_errors;
    int start_items;
    start_errors = errors;
    start_items  = total_items;
    while (total_items - start_items < TEST_ITEMS) begin
      @(negedge clk);
      decode_ready   = ($unsigned($random(seed)) % 100) < ready_pct;
      redirect.valid = ($unsigned($random(seed)) % 100) < redirect_pct;
      redirect.pc    = RESET_PC + 64'(($unsigned($random(seed)) % 64) * 4);
      check_cycle();
    end
    $display("%s: %0d items, %0d errors", name, total_items - start_items,
             errors - start_errors);
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    redirect     = '0;
    decode_ready = 1'b0;
    seed         = 2978;
    errors       = 0;
    total_items  = 0;
    hold_pending = 1'b0;
    fill_table();
    build_expected(RESET_PC);

    repeat (4) @(negedge clk);
    assert (!decode_valid && !icache_req.en) else begin
      $display("** Error at %0t: decode_valid or icache request high after reset", $time);
      errors++;
    end
    rst          = 1'b0;
    decode_ready = 1'b1;

    run_test("sequential fetch", 100, 0);
    run_test("decode back-pressure", 50, 0);
    run_test("redirects under back-pressure", 50, 8);

    $display("%0d tests, %0d items checked, %0d errors", NUM_TESTS, total_items, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("run timed out after %0d cycles, %0d items checked", TIMEOUT_CYCLES, total_items);
    $display("Test failed");
    $finish;
  end

endmodule

//--- compile.f
verilog/fetch_pkg.sv
verilog/pc_sequencer.sv
verilog/fetch_buffer.sv
verilog/amo_expander.sv
verilog/fetch_unit.sv
testbench/icache_model.sv
testbench/tb_fetch_unit.sv
